// ==== source/glue_pkg.sv ====
/*
 * Shared memory map, widths, bus structs and reset FSM states for the system glue.
 * Every glue module imports this package.
 */
package glue_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int ADDR_W      = 23;	// word address, byte bits 23..1
	localparam int DATA_W      = 16;
	localparam int BYTE_W      = 8;
	localparam int RTC_FIELD_W = 4;	// one clock digit
	localparam int RTC_SEL_W   = 4;	// sixteen digits
	localparam int IRQ_LEVELS  = 7;
	localparam int IPL_W       = 3;
	localparam int FRAME_W     = 2;

	typedef logic [ADDR_W-1:0]                        word_addr_t;
	typedef logic [DATA_W-1:0]                        data_t;
	typedef logic [BYTE_W-1:0]                        byte_t;
	typedef logic [RTC_FIELD_W*(1<<RTC_SEL_W)-1:0]    rtc_t;
	typedef logic [IPL_W-1:0]                         ipl_t;	// active low
	typedef logic [IRQ_LEVELS-1:0]                    irq_req_t;	// bit 0 is level 1
	typedef logic [FRAME_W-1:0]                       frame_cnt_t;

	// ----------------------------------------
	// memory map, all as word addresses
	// ----------------------------------------
	localparam word_addr_t CHIP_TOP    = 23'h0F_FFFF;	// byte 1FFFFF
	localparam word_addr_t OVL_TOP     = 23'h03_FFFF;	// byte 07FFFF
	localparam word_addr_t CIA_BASE    = 23'h5F_8000;	// byte BF0000, 64k region
	localparam word_addr_t RTC_BASE    = 23'h6E_0000;	// byte DC0000, 64k region
	localparam word_addr_t CUSTOM_BASE = 23'h6F_F800;	// byte DFF000, 4k page
	localparam word_addr_t KICK_BASE   = 23'h7C_0000;	// byte F80000 up to the top

	localparam int REGION_LSB  = 15;	// word bit of byte bit 16
	localparam int PAGE_LSB    = 11;	// word bit of byte bit 12
	localparam int CIA_A_BIT   = 11;	// byte bit 12, low for cia a
	localparam int CIA_B_BIT   = 12;	// byte bit 13, low for cia b
	localparam int RTC_IDX_LSB = 1;	// byte bits 5..2 pick the digit

	// reset sequencing
	localparam int RESET_FRAMES = 3;	// frame starts before release
	localparam int CPU_RST_SYNC = 2;	// flops on the cpu reset

	typedef struct packed {
		word_addr_t addr;
		logic       as;	// address strobe, high = valid
		logic       rd;
		logic       hwr;	// upper byte write
		logic       lwr;	// lower byte write
	} cpu_bus_t;

	typedef struct packed {
		logic chip;
		logic kick;
		logic cia_a;
		logic cia_b;
		logic custom;
		logic rtc;
	} sel_t;

	typedef enum logic [1:0] {
		RST_HOLD,
		RST_COUNT,
		RST_RUN
	} rst_state_t;

endpackage

// ==== source/sys_reset_ctrl.sv ====
/*
 * System reset sequencer. Holds sys_rst while a reset request is present,
 * then waits a fixed number of frame starts. cpu_reset_n trails it by a short sync chain.
 */
module sys_reset_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic sof,	// one-cycle frame start
	input  logic usr_rst,	// level from the user side
	output logic sys_rst,
	output logic cpu_reset_n
);
	import glue_pkg::*;

	rst_state_t                state;
	frame_cnt_t                frames;	// sof pulses seen since the request dropped
	logic [CPU_RST_SYNC-1:0]   sync;	// cpu reset release chain

	// ----------------------------------------
	// reset FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst || usr_rst) begin	// any request restarts the sequence
			state  <= RST_HOLD;
			frames <= '0;
		end else begin
			case (state)
				RST_HOLD: begin
					state  <= RST_COUNT;	// request gone, start counting frames
					frames <= '0;
				end
				RST_COUNT: begin
					if (sof) begin
						// last frame start releases the system
						if (frames == frame_cnt_t'(RESET_FRAMES - 1))
							state <= RST_RUN;
						frames <= frames + 1'b1;
					end
				end
				RST_RUN: ;	// stay until the next request
				default: state <= RST_HOLD;	// unused encoding
			endcase
		end
	end

	assign sys_rst = (state != RST_RUN);

	// cpu reset follows sys_rst through the chain, both edges
	always_ff @(posedge clk) begin
		if (rst)
			sync <= '0;	// cpu held in reset
		else
			sync <= {sync[CPU_RST_SYNC-2:0], ~sys_rst};
	end

	assign cpu_reset_n = sync[CPU_RST_SYNC-1];

	// cpu must be in reset once sys_rst has been up for the full chain length
	a_cpu_rst_follows: assert property (@(posedge clk) disable iff (rst)
		sys_rst [*CPU_RST_SYNC] |=> !cpu_reset_n);

endmodule

// ==== source/addr_decode.sv ====
/*
 * CPU address decoder. Turns the bus address into one-hot chip selects
 * and keeps the kickstart overlay flag, cleared by the first CIA A write.
 */
module addr_decode (
	input  logic              clk,
	input  logic              sys_rst,
	input  glue_pkg::cpu_bus_t cpu,
	output glue_pkg::sel_t     sel
);
	import glue_pkg::*;

	logic ovl;	// rom mapped over low chip ram
	logic in_chip;
	logic in_ovl;
	logic in_cia;
	logic in_rtc;
	logic in_custom;
	logic in_kick;
	logic cia_a_wr;

	// ----------------------------------------
	// region compares
	// ----------------------------------------
	assign in_chip   = (cpu.addr <= CHIP_TOP);
	assign in_ovl    = ovl && (cpu.addr <= OVL_TOP);	// low 512k while overlay is on
	assign in_cia    = (cpu.addr[ADDR_W-1:REGION_LSB] == CIA_BASE[ADDR_W-1:REGION_LSB]);
	assign in_rtc    = (cpu.addr[ADDR_W-1:REGION_LSB] == RTC_BASE[ADDR_W-1:REGION_LSB]);
	assign in_custom = (cpu.addr[ADDR_W-1:PAGE_LSB] == CUSTOM_BASE[ADDR_W-1:PAGE_LSB]);
	assign in_kick   = (cpu.addr >= KICK_BASE);	// 512k rom at the top

	// selects, all quiet without address strobe
	always_comb begin
		sel = '0;
		if (cpu.as) begin
			sel.chip   = in_chip & ~in_ovl;
			sel.kick   = in_kick | in_ovl;	// overlay redirects to rom
			// cia a sits on byte bit 12 low, cia b on bit 13 low
			sel.cia_a  = in_cia & ~cpu.addr[CIA_A_BIT];
			sel.cia_b  = in_cia & ~cpu.addr[CIA_B_BIT] & cpu.addr[CIA_A_BIT];
			sel.rtc    = in_rtc;
			sel.custom = in_custom;
		end
	end

	// ----------------------------------------
	// kickstart overlay
	// ----------------------------------------
	assign cia_a_wr = sel.cia_a & (cpu.hwr | cpu.lwr);

	always_ff @(posedge clk) begin
		if (sys_rst)
			ovl <= 1'b1;	// rom visible at 0 for the reset vectors
		else if (cia_a_wr)
			ovl <= 1'b0;	// boot code turned it off
	end

	// regions never overlap, overlay included
	a_sel_onehot: assert property (@(posedge clk) $onehot0(sel));

endmodule

// ==== source/cpu_read_mux.sv ====
/*
 * CPU read data return. Each source is gated by its select and the results ORed.
 * RTC reads return one clock digit picked by the low address bits.
 */
module cpu_read_mux (
	input  glue_pkg::cpu_bus_t cpu,
	input  glue_pkg::sel_t     sel,
	input  glue_pkg::data_t    mem_rdata,	// ram and rom share this
	input  glue_pkg::data_t    custom_rdata,
	input  glue_pkg::byte_t    cia_a_rdata,
	input  glue_pkg::byte_t    cia_b_rdata,
	input  glue_pkg::rtc_t     rtc,
	output glue_pkg::data_t    cpu_rdata
);
	import glue_pkg::*;

	logic [RTC_SEL_W-1:0]   rtc_idx;
	logic [RTC_FIELD_W-1:0] rtc_field;
	data_t                  mem_part;
	data_t                  custom_part;
	data_t                  cia_a_part;
	data_t                  cia_b_part;
	data_t                  rtc_part;

	// digit number from byte address bits 5..2
	assign rtc_idx   = cpu.addr[RTC_IDX_LSB +: RTC_SEL_W];
	assign rtc_field = rtc[rtc_idx * RTC_FIELD_W +: RTC_FIELD_W];

	// ----------------------------------------
	// gated sources
	// ----------------------------------------
	assign mem_part    = (sel.chip | sel.kick) ? mem_rdata : '0;
	assign custom_part = sel.custom ? custom_rdata : '0;
	assign cia_a_part  = sel.cia_a ? data_t'(cia_a_rdata) : '0;	// odd byte, low lane
	assign cia_b_part  = sel.cia_b ? {cia_b_rdata, {BYTE_W{1'b0}}} : '0;	// even byte, high lane
	assign rtc_part    = sel.rtc ? data_t'(rtc_field) : '0;	// zero extended

	// merged bus, zero outside read cycles
	always_comb begin
		cpu_rdata = '0;
		if (cpu.rd)
			cpu_rdata = mem_part | custom_part | cia_a_part | cia_b_part | rtc_part;
	end

endmodule

// ==== source/irq_encoder.sv ====
/*
 * Interrupt priority encoder. Highest active request level becomes the
 * active-low ipl code, registered once. Level 7 beats everything below.
 */
module irq_encoder (
	input  logic              clk,
	input  logic              sys_rst,
	input  glue_pkg::irq_req_t irq_req,	// bit 0 = level 1
	output glue_pkg::ipl_t     ipl_n
);
	import glue_pkg::*;

	ipl_t level;	// highest active level, 0 = none

	// later bits overwrite earlier ones, so the top level wins
	always_comb begin
		level = '0;
		for (int i = 0; i < IRQ_LEVELS; i++) begin
			if (irq_req[i])
				level = ipl_t'(i + 1);
		end
	end

	always_ff @(posedge clk) begin
		if (sys_rst)
			ipl_n <= '1;	// no interrupt
		else
			ipl_n <= ~level;
	end

	// idle request lines give an idle code on the next clock
	a_idle_ipl: assert property (@(posedge clk) (irq_req == '0) |=> (ipl_n == '1));

endmodule

// ==== source/glue_top.sv ====
/*
 * System glue top level. Decoder, read return, interrupt encoder and
 * reset sequencer wired to the CPU bus and the external peripherals.
 */
module glue_top (
	input  logic               clk,
	input  logic               rst,
	input  glue_pkg::cpu_bus_t cpu,
	input  logic               sof,	// frame start pulse from video
	input  logic               usr_rst,
	input  glue_pkg::data_t    mem_rdata,	// shared ram / rom data
	input  glue_pkg::data_t    custom_rdata,
	input  glue_pkg::byte_t    cia_a_rdata,
	input  glue_pkg::byte_t    cia_b_rdata,
	input  glue_pkg::rtc_t     rtc,
	input  glue_pkg::irq_req_t irq_req,
	output glue_pkg::sel_t     sel,
	output glue_pkg::data_t    cpu_rdata,
	output glue_pkg::ipl_t     ipl_n,
	output logic               sys_rst,
	output logic               cpu_reset_n
);

	// ----------------------------------------
	// reset sequencing
	// ----------------------------------------
	sys_reset_ctrl u_reset (
		.clk         (clk),
		.rst         (rst),
		.sof         (sof),
		.usr_rst     (usr_rst),
		.sys_rst     (sys_rst),
		.cpu_reset_n (cpu_reset_n)
	);

	// ----------------------------------------
	// bus decode and read return
	// ----------------------------------------
	addr_decode u_decode (
		.clk     (clk),
		.sys_rst (sys_rst),	// re-arms the overlay
		.cpu     (cpu),
		.sel     (sel)
	);

	cpu_read_mux u_read (
		.cpu          (cpu),
		.sel          (sel),
		.mem_rdata    (mem_rdata),
		.custom_rdata (custom_rdata),
		.cia_a_rdata  (cia_a_rdata),
		.cia_b_rdata  (cia_b_rdata),
		.rtc          (rtc),
		.cpu_rdata    (cpu_rdata)
	);

	// interrupt code to the cpu
	irq_encoder u_irq (
		.clk     (clk),
		.sys_rst (sys_rst),
		.irq_req (irq_req),
		.ipl_n   (ipl_n)
	);

endmodule

// ==== verif/tb_clock.sv ====
/*
 * Testbench clock and reset source. Free running clock,
 * reset held high for the first few rising edges.
 */
module tb_clock (
	output logic clk,
	output logic rst
);
	localparam int HALF_PERIOD  = 20;	// 40 unit period
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);	// drop away from the active edge
		rst = 1'b0;
	end

endmodule

// ==== verif/tb_glue.sv ====
/*
 * Testbench for the system glue. Drives random bus cycles, interrupt requests
 * and resets, and checks every clock against a cycle model of the glue.
 */
module tb_glue;
	import glue_pkg::*;

	localparam int SOF_PERIOD     = 16;
	localparam int TIMEOUT_CYCLES = 5000;	// about twice the stimulus length

	logic     clk;
	logic     rst;
	logic     sof;
	logic     usr_rst;
	logic     sys_rst;
	logic     cpu_reset_n;
	cpu_bus_t cpu;
	data_t    mem_rdata;
	data_t    custom_rdata;
	data_t    cpu_rdata;
	byte_t    cia_a_rdata;
	byte_t    cia_b_rdata;
	rtc_t     rtc;
	irq_req_t irq_req;
	sel_t     sel;
	ipl_t     ipl_n;

	logic [31:0] seed        = 32'hf27f;
	int          cycle_count = 0;
	int          sof_div     = 0;
	int          rst_edges   = 0;	// checks start once the dut state is known

	// model state mirrors each dut register during the current cycle
	logic                    ref_ovl     = 1'b1;
	logic                    ref_sys_rst = 1'b1;
	logic [CPU_RST_SYNC-1:0] ref_delay   = '0;	// sys_rst delay line for cpu reset
	ipl_t                    ref_ipl     = '1;
	int                      ref_frames  = 0;	// frame starts since the request dropped
	logic                    req_gone    = 1'b0;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	glue_top u_dut (.*);

	// ----------------------------------------
	// random numbers and reference model
	// ----------------------------------------
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ {16'h0, seed[31:16]};	// fold the better upper bits down
	endfunction

	// address in one region or anywhere in the map
	function automatic word_addr_t random_addr();
		logic [31:0] r;
		r = lcg_next();
		case (r[31:29])
			3'd0:    return word_addr_t'(r[19:0]);	// chip ram
			3'd1:    return word_addr_t'(r[17:0]);	// overlay area
			3'd2:    return {8'hBF, r[14:0]};	// cia
			3'd3:    return {8'hDC, r[14:0]};	// rtc
			3'd4:    return {12'hDFF, r[10:0]};	// custom page
			3'd5:    return {5'h1F, r[17:0]};	// kickstart
			default: return r[22:0];
		endcase
	endfunction

	function automatic sel_t ref_sel(cpu_bus_t b, logic ovl);
		logic [23:0] a;
		sel_t        s;
		a = {b.addr, 1'b0};	// byte address
		s = '0;
		if (b.as) begin
			s.kick   = (a >= 24'hF80000) || (ovl && a <= 24'h07FFFF);
			s.chip   = (a <= 24'h1FFFFF) && !s.kick;
			s.cia_a  = (a[23:16] == 8'hBF) && !a[12];
			s.cia_b  = (a[23:16] == 8'hBF) && !a[13] && a[12];
			s.rtc    = (a[23:16] == 8'hDC);
			s.custom = (a[23:12] == 12'hDFF);
		end
		return s;
	endfunction

	function automatic data_t ref_rdata(cpu_bus_t b, sel_t s);
		logic [23:0] a;
		data_t       d;
		a = {b.addr, 1'b0};
		d = '0;
		if (b.rd) begin
			if (s.chip || s.kick)
				d |= mem_rdata;
			if (s.custom)
				d |= custom_rdata;
			if (s.cia_a)
				d |= {8'h00, cia_a_rdata};	// low lane
			if (s.cia_b)
				d |= {cia_b_rdata, 8'h00};	// high lane
			if (s.rtc)
				d |= data_t'((rtc >> (a[5:2] * 4)) & 64'hF);
		end
		return d;
	endfunction

	function automatic ipl_t ref_ipl_code(irq_req_t req);
		for (int lvl = 7; lvl >= 1; lvl--) begin
			if (req[lvl-1])
				return ~ipl_t'(lvl);	// highest level wins
		end
		return '1;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	// ----------------------------------------
	// compare and model update, every rising edge
	// ----------------------------------------
	always @(posedge clk) begin
		sel_t  exp_sel;
		data_t exp_rdata;
		exp_sel   = ref_sel(cpu, ref_ovl);
		exp_rdata = ref_rdata(cpu, exp_sel);
		if (rst_edges >= 2) begin
			assert (sel === exp_sel) else report_mismatch("sel", exp_sel, sel);
			assert (cpu_rdata === exp_rdata)
				else report_mismatch("cpu_rdata", exp_rdata, cpu_rdata);
			assert (ipl_n === ref_ipl) else report_mismatch("ipl_n", ref_ipl, ipl_n);
			assert (sys_rst === ref_sys_rst)
				else report_mismatch("sys_rst", ref_sys_rst, sys_rst);
			assert (cpu_reset_n === ref_delay[CPU_RST_SYNC-1])
				else report_mismatch("cpu_reset_n", ref_delay[CPU_RST_SYNC-1], cpu_reset_n);
		end
		if (rst)
			rst_edges++;
		ref_ipl = ref_sys_rst ? '1 : ref_ipl_code(irq_req);
		if (ref_sys_rst)
			ref_ovl = 1'b1;	// rom back over chip ram
		else if (exp_sel.cia_a && (cpu.hwr || cpu.lwr))
			ref_ovl = 1'b0;
		ref_delay = rst ? '0 : {ref_delay[CPU_RST_SYNC-2:0], ~ref_sys_rst};
		if (rst || usr_rst) begin
			ref_sys_rst = 1'b1;
			ref_frames  = 0;
			req_gone    = 1'b0;
		end else if (!req_gone) begin
			req_gone = 1'b1;	// sof on the edge that sees the request gone is not counted
		end else if (ref_sys_rst && sof) begin
			ref_frames++;
			if (ref_frames == RESET_FRAMES)
				ref_sys_rst = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "stopped by the watchdog");
		end
	end

	always @(negedge clk) begin	// frame start pulse
		sof_div++;
		sof = (sof_div % SOF_PERIOD == 0);
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic bus_cycle(input word_addr_t addr, input logic as, input logic rd,
			input logic hwr, input logic lwr);
		@(negedge clk);
		cpu          = {addr, as, rd, hwr, lwr};
		mem_rdata    = data_t'(lcg_next());	// fresh data on every source
		custom_rdata = data_t'(lcg_next());
		cia_a_rdata  = byte_t'(lcg_next());
		cia_b_rdata  = byte_t'(lcg_next());
		rtc          = {lcg_next(), lcg_next()};
	endtask

	task automatic wait_release();
		while (sys_rst !== 1'b0)
			bus_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
		while (cpu_reset_n !== 1'b1)
			bus_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic low_reads(input int n);
		repeat (n)
			bus_cycle(word_addr_t'(lcg_next() & 32'h3FFFF), 1'b1, 1'b1, 1'b0, 1'b0);
	endtask

	initial begin
		logic [31:0] r;
		cpu          = '0;
		sof          = 1'b0;
		usr_rst      = 1'b0;
		mem_rdata    = '0;
		custom_rdata = '0;
		cia_a_rdata  = '0;
		cia_b_rdata  = '0;
		rtc          = '0;
		irq_req      = '0;

		wait_release();	// power-on sequence
		low_reads(40);	// overlay on so rom sits at zero
		bus_cycle({8'hBF, 15'h0}, 1'b1, 1'b0, 1'b0, 1'b1);	// cia a write
		low_reads(40);	// chip ram back

		repeat (1500) begin	// random decode and read return
			r = lcg_next();
			bus_cycle(random_addr(), r[2:0] != 3'd0, r[3], ~r[3] & r[4], ~r[3] & r[5]);
		end

		repeat (300) begin	// interrupt priority
			r = lcg_next();
			bus_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
			irq_req = irq_req_t'(r);
			if (r[10:8] == 3'd0)
				irq_req[6] = 1'b1;	// freeze button
			else if (r[13:11] == 3'd0)
				irq_req = '0;
		end

		// user reset in mid-run
		bus_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
		usr_rst = 1'b1;
		repeat (6)
			bus_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0);
		usr_rst = 1'b0;
		wait_release();
		low_reads(40);	// overlay re-armed
		bus_cycle({8'hBF, 15'h0800}, 1'b1, 1'b0, 1'b1, 1'b1);	// cia b write keeps rom
		low_reads(20);
		bus_cycle({8'hBF, 15'h0}, 1'b1, 1'b0, 1'b1, 1'b0);	// upper byte cia a write
		low_reads(20);	// chip ram back

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
source/glue_pkg.sv
source/sys_reset_ctrl.sv
source/addr_decode.sv
source/cpu_read_mux.sv
source/irq_encoder.sv
source/glue_top.sv
verif/tb_clock.sv
verif/tb_glue.sv

// ==== Bender.yml ====
package:
  name: glue

sources:
  - source/glue_pkg.sv
  - source/sys_reset_ctrl.sv
  - source/addr_decode.sv
  - source/cpu_read_mux.sv
  - source/irq_encoder.sv
  - source/glue_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_glue.sv
